//--- src/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

    localparam int ADDR_W     = 20;  // Bus address width
    localparam int DATA_W     = 8;   // Bus data width
    localparam int MEM_ADDR_W = 10;  // Address bits decoded by the memory

    // Opcode in bits 7..5 of the command byte
    typedef enum logic [2:0] {
        CMD_WRITE_AT  = 3'd1,
        CMD_READ_AT   = 3'd2,
        CMD_READ_NEXT = 3'd3
    } cmd_e;

    typedef enum logic [2:0] {
        ST_CMD,      // Waiting for command byte
        ST_ADDR_HI,  // Address bits 15..8
        ST_ADDR_LO,  // Address bits 7..0
        ST_DATA,     // Write data byte
        ST_BUS,      // Bus cycle pending
        ST_REPLY,    // Read data queued for the host
        ST_IDLE      // Frame done, wait for next CS fall
    } dec_state_e;

endpackage

`default_nettype wire

//--- src/bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bus_if import spi_bridge_pkg::*; ();

    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              we;
    logic              cycle;  // Held until ack
    logic              ack;    // Single-clock pulse from the slave

    modport master (output addr, wdata, we, cycle, input rdata, ack);
    modport slave (input addr, wdata, we, cycle, output rdata, ack);

endinterface

`default_nettype wire

//--- src/spi_sync.sv
`timescale 1ns/1ns
`default_nettype none

module spi_sync (
    input  logic clock,
    input  logic rst_n_i,
    input  logic sck_i,
    input  logic cs_n_i,
    input  logic sd_i,
    output logic sck_rise_o,
    output logic sck_fall_o,
    output logic frame_start_o,
    output logic frame_end_o,
    output logic sd_o
);

    // Bit 0 is SCK, bit 1 is CS_N, bit 2 is the data pin
    logic [2:0] meta_q;
    logic [2:0] sync_q;
    logic [1:0] prev_q;  // Delayed copy of SCK and CS_N for edge detect

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            meta_q        <= 3'b010;  // CS_N idles high
            sync_q        <= 3'b010;
            prev_q        <= 2'b10;
            sck_rise_o    <= 1'b0;
            sck_fall_o    <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            sd_o          <= 1'b0;
        end else begin
            meta_q        <= {sd_i, cs_n_i, sck_i};
            sync_q        <= meta_q;
            prev_q        <= sync_q[1:0];
            sck_rise_o    <= sync_q[0] & ~prev_q[0];
            sck_fall_o    <= ~sync_q[0] & prev_q[0];
            frame_start_o <= ~sync_q[1] & prev_q[1];  // CS_N fell
            frame_end_o   <= sync_q[1] & ~prev_q[1];  // CS_N rose
            sd_o          <= sync_q[2];               // Aligned with the SCK pulses
        end
    end

endmodule

`default_nettype wire

//--- src/spi_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module spi_shifter import spi_bridge_pkg::*; (
    input  logic              clock,
    input  logic              rst_n_i,
    input  logic              sck_rise_i,
    input  logic              sck_fall_i,
    input  logic              frame_start_i,
    input  logic              sd_i,
    input  logic              tx_load_i,
    input  logic [DATA_W-1:0] tx_byte_i,
    output logic [DATA_W-1:0] rx_byte_o,
    output logic              rx_valid_o,
    output logic              sd_o
);

    logic [DATA_W-1:0] rx_sr;
    logic [DATA_W-1:0] tx_sr;
    logic [2:0]        bit_cnt;  // Bits taken in the current byte

    // Mode 0 receive, MSB first
    always_ff @(posedge clock) begin
        if (sck_rise_i) begin
            rx_sr <= {rx_sr[DATA_W-2:0], sd_i};
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            bit_cnt    <= 3'd0;
            rx_valid_o <= 1'b0;
            tx_sr      <= '0;
        end else begin
            rx_valid_o <= 1'b0;
            if (frame_start_i) begin
                bit_cnt <= 3'd0;
                tx_sr   <= '0;
            end else begin
                if (sck_rise_i) begin
                    bit_cnt    <= bit_cnt + 3'd1;     // Wraps to 0 after the eighth bit
                    rx_valid_o <= (bit_cnt == 3'd7);
                end
                if (tx_load_i) begin
                    tx_sr <= tx_byte_i;
                end else if (sck_fall_i && bit_cnt != 3'd0) begin
                    // Trailing fall after bit 8 keeps the next MSB on the pin
                    tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
                end
            end
        end
    end

    assign rx_byte_o = rx_sr;  // Stable until the next rising edge
    assign sd_o      = tx_sr[DATA_W-1];

endmodule

`default_nettype wire

//--- src/spi_cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_decoder import spi_bridge_pkg::*; (
    input  logic              clock,
    input  logic              rst_n_i,
    input  logic              frame_start_i,
    input  logic              frame_end_i,
    input  logic              rx_valid_i,
    input  logic [DATA_W-1:0] rx_byte_i,
    output logic [DATA_W-1:0] tx_byte_o,
    output logic              tx_load_o,
    output logic              stall_o,
    bus_if.master             bus
);

    dec_state_e        state;
    cmd_e              opcode;
    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] next_addr;  // Address used by READ_NEXT
    logic [DATA_W-1:0] wdata_q;
    logic              we_q;
    logic              cycle_q;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state     <= ST_CMD;
            next_addr <= '0;
            we_q      <= 1'b0;
            cycle_q   <= 1'b0;
            stall_o   <= 1'b0;
            tx_load_o <= 1'b0;
        end else begin
            tx_load_o <= 1'b0;
            if (frame_start_i) begin
                state   <= ST_CMD;  // Drops any open cycle
                cycle_q <= 1'b0;
                stall_o <= 1'b0;
            end else if (frame_end_i && state != ST_BUS) begin
                state <= ST_IDLE;   // Partial frame is discarded
            end else begin
                case (state)
                    ST_CMD: if (rx_valid_i) begin
                        opcode         <= cmd_e'(rx_byte_i[7:5]);
                        addr_q[19:16]  <= rx_byte_i[3:0];
                        case (cmd_e'(rx_byte_i[7:5]))
                            CMD_WRITE_AT, CMD_READ_AT: state <= ST_ADDR_HI;
                            CMD_READ_NEXT: begin
                                addr_q  <= next_addr;
                                we_q    <= 1'b0;
                                cycle_q <= 1'b1;
                                stall_o <= 1'b1;
                                state   <= ST_BUS;
                            end
                            default: state <= ST_IDLE;  // Unknown opcode
                        endcase
                    end
                    ST_ADDR_HI: if (rx_valid_i) begin
                        addr_q[15:8] <= rx_byte_i;
                        state        <= ST_ADDR_LO;
                    end
                    ST_ADDR_LO: if (rx_valid_i) begin
                        addr_q[7:0] <= rx_byte_i;
                        if (opcode == CMD_WRITE_AT) begin
                            state <= ST_DATA;
                        end else begin
                            we_q    <= 1'b0;
                            cycle_q <= 1'b1;
                            stall_o <= 1'b1;
                            state   <= ST_BUS;
                        end
                    end
                    ST_DATA: if (rx_valid_i) begin
                        wdata_q <= rx_byte_i;
                        we_q    <= 1'b1;
                        cycle_q <= 1'b1;
                        stall_o <= 1'b1;
                        state   <= ST_BUS;
                    end
                    ST_BUS: if (bus.ack) begin
                        cycle_q   <= 1'b0;
                        stall_o   <= 1'b0;
                        next_addr <= addr_q + 20'd1;  // Wraps at 20 bits
                        if (we_q) begin
                            state <= ST_IDLE;
                        end else begin
                            tx_byte_o <= bus.rdata;
                            tx_load_o <= 1'b1;
                            state     <= ST_REPLY;
                        end
                    end
                    ST_REPLY: if (rx_valid_i) begin
                        state <= ST_IDLE;  // Reply byte has gone out
                    end
                    default: ;             // ST_IDLE waits for CS fall
                endcase
            end
        end
    end

    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.we    = we_q;
    assign bus.cycle = cycle_q;

endmodule

`default_nettype wire

//--- src/bus_memory.sv
`timescale 1ns/1ns
`default_nettype none

module bus_memory import spi_bridge_pkg::*; (
    input  logic clock,
    input  logic rst_n_i,
    bus_if.slave bus
);

    logic [DATA_W-1:0]     mem [0:(1 << MEM_ADDR_W)-1];
    logic [MEM_ADDR_W-1:0] index;
    logic                  ack_q;
    logic [DATA_W-1:0]     rdata_q;
    logic                  start;

    assign index = bus.addr[MEM_ADDR_W-1:0];  // Upper bits alias
    assign start = bus.cycle && !ack_q;       // New cycle not yet answered

    always_ff @(posedge clock) begin
        if (start && bus.we) begin
            mem[index] <= bus.wdata;
        end
        if (start) begin
            rdata_q <= mem[index];  // Valid together with ack
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= start;  // One clock pulse, master drops cycle next
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- src/spi_bridge_top.sv
`timescale 1ns/1ns
`default_nettype none

module spi_bridge_top import spi_bridge_pkg::*; (
    input  logic clock,
    input  logic rst_n_i,
    input  logic spi_sck_i,
    input  logic spi_cs_n_i,
    input  logic spi_pico_i,
    output logic spi_poci_o,
    output logic spi_stall_o
);

    logic              sck_rise;
    logic              sck_fall;
    logic              frame_start;
    logic              frame_end;
    logic              sd;
    logic [DATA_W-1:0] rx_byte;
    logic              rx_valid;
    logic [DATA_W-1:0] tx_byte;
    logic              tx_load;

    bus_if bus ();

    spi_sync u_sync (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .sck_i         (spi_sck_i),
        .cs_n_i        (spi_cs_n_i),
        .sd_i          (spi_pico_i),
        .sck_rise_o    (sck_rise),
        .sck_fall_o    (sck_fall),
        .frame_start_o (frame_start),
        .frame_end_o   (frame_end),
        .sd_o          (sd)
    );

    spi_shifter u_shifter (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .sck_rise_i    (sck_rise),
        .sck_fall_i    (sck_fall),
        .frame_start_i (frame_start),
        .sd_i          (sd),
        .tx_load_i     (tx_load),
        .tx_byte_i     (tx_byte),
        .rx_byte_o     (rx_byte),
        .rx_valid_o    (rx_valid),
        .sd_o          (spi_poci_o)
    );

    spi_cmd_decoder u_decoder (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .frame_start_i (frame_start),
        .frame_end_i   (frame_end),
        .rx_valid_i    (rx_valid),
        .rx_byte_i     (rx_byte),
        .tx_byte_o     (tx_byte),
        .tx_load_o     (tx_load),
        .stall_o       (spi_stall_o),
        .bus           (bus.master)
    );

    bus_memory u_memory (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .bus     (bus.slave)
    );

endmodule

`default_nettype wire

//--- test/spi_host.sv
`timescale 1ns/1ns
`default_nettype none

module spi_host (
    input  logic clock,
    input  logic poci_i,
    input  logic stall_i,
    output logic sck_o,
    output logic cs_n_o,
    output logic pico_o
);

    localparam int HALF_CLKS   = 4;    // SCK half period in clocks
    localparam int STALL_LIMIT = 200;  // Clocks allowed for a pending read

    // Ends 10 ns after the edge that closes a half period
    task automatic half_wait();
        repeat (HALF_CLKS) @(posedge clock);
        #10;
    endtask

    task automatic init_pins();
        sck_o  = 1'b0;
        cs_n_o = 1'b1;
        pico_o = 1'b0;
    endtask

    task automatic frame_begin();
        cs_n_o = 1'b0;
        half_wait();
    endtask

    task automatic frame_finish();
        half_wait();
        cs_n_o = 1'b1;
        half_wait();  // CS_N high long enough to be seen
    endtask

    // Mode 0, MSB first; POCI read late in the high phase
    task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            pico_o = tx[i];
            half_wait();
            sck_o = 1'b1;
            half_wait();
            rx[i] = poci_i;
            sck_o = 1'b0;
        end
    endtask

    task automatic wait_stall_low(output logic released);
        int waited;
        waited = 0;
        half_wait();  // Last command byte reaches the decoder
        while (stall_i && waited < STALL_LIMIT) begin
            @(posedge clock);
            #10;
            waited++;
        end
        released = !stall_i;
    endtask

endmodule

`default_nettype wire

//--- test/spi_bridge_tb.sv
`timescale 1ns/1ns
`default_nettype none

module spi_bridge_tb import spi_bridge_pkg::*; ();

    localparam int N_DIRECTED = 12;
    localparam int N_RANDOM   = 300;
    localparam int LIMIT_NS   = (N_DIRECTED + N_RANDOM) * 40 * 4 * 100 * 2;

    logic              clock;
    logic              rst_n_i;
    logic              sck;
    logic              cs_n;
    logic              pico;
    logic              poci;
    logic              stall;
    logic [DATA_W-1:0] model_mem [int];  // Keyed by the low 10 address bits
    logic [ADDR_W-1:0] model_next;
    logic [ADDR_W-1:0] pool [16];
    logic [31:0]       lfsr_q;
    int                checks;
    int                errors;
    int                stall_fails;

    spi_bridge_top uut (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .spi_sck_i   (sck),
        .spi_cs_n_i  (cs_n),
        .spi_pico_i  (pico),
        .spi_poci_o  (poci),
        .spi_stall_o (stall)
    );

    spi_host host (
        .clock   (clock),
        .poci_i  (poci),
        .stall_i (stall),
        .sck_o   (sck),
        .cs_n_o  (cs_n),
        .pico_o  (pico)
    );

    always #50 clock = ~clock;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_data(input string what, input logic [DATA_W-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input logic [ADDR_W-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic write_at(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] rx;
        host.frame_begin();
        host.xfer_byte({CMD_WRITE_AT, 1'b0, a[19:16]}, rx);
        host.xfer_byte(a[15:8], rx);
        host.xfer_byte(a[7:0], rx);
        host.xfer_byte(d, rx);
        host.frame_finish();
        model_mem[int'(a[MEM_ADDR_W-1:0])] = d;
        model_next = a + 20'd1;
        check_addr("next address after write", uut.u_decoder.next_addr, model_next);
    endtask

    task automatic read_cmd(input cmd_e op, input logic [ADDR_W-1:0] addr_in);
        logic [DATA_W-1:0] rx;
        logic [ADDR_W-1:0] a;
        logic              released;
        a = (op == CMD_READ_AT) ? addr_in : model_next;  // READ_NEXT follows the model
        host.frame_begin();
        host.xfer_byte({op, 1'b0, a[19:16]}, rx);
        if (op == CMD_READ_AT) begin
            host.xfer_byte(a[15:8], rx);
            host.xfer_byte(a[7:0], rx);
        end
        host.wait_stall_low(released);
        if (!released) begin
            stall_fails++;
            $display("stall stayed high after a read command at %0t", $time);
        end
        host.xfer_byte(8'h00, rx);
        host.frame_finish();
        if (model_mem.exists(int'(a[MEM_ADDR_W-1:0]))) begin
            check_data("read data", rx, model_mem[int'(a[MEM_ADDR_W-1:0])]);
        end
        model_next = a + 20'd1;
        check_addr("next address after read", uut.u_decoder.next_addr, model_next);
    endtask

    initial begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        clock       = 1'b0;
        rst_n_i     = 1'b0;
        lfsr_q      = 32'd99424;
        model_next  = '0;
        checks      = 0;
        errors      = 0;
        stall_fails = 0;
        host.init_pins();
        repeat (16) @(posedge clock);
        #10;
        rst_n_i = 1'b1;
        @(posedge clock);
        #10;
        check_flag("stall after reset", stall, 1'b0);
        check_flag("POCI after reset", poci, 1'b0);

        write_at(20'h0A5C3, 8'h3C);
        read_cmd(CMD_READ_AT, 20'h0A5C3);
        write_at(20'h12345, 8'h5A);
        read_cmd(CMD_READ_AT, 20'h00345);  // Same low 10 bits as 20'h12345
        write_at(20'hFFFFE, 8'h11);
        write_at(20'hFFFFF, 8'h22);
        write_at(20'h00000, 8'h33);
        write_at(20'h00001, 8'h44);
        read_cmd(CMD_READ_AT, 20'hFFFFE);
        repeat (3) read_cmd(CMD_READ_NEXT, '0);  // Crosses 20'hFFFFF to 0

        // Upper half of the pool aliases the lower half
        for (int i = 0; i < 8; i++) begin
            take_bits(ADDR_W, r);
            pool[i] = r[ADDR_W-1:0];
            take_bits(ADDR_W - MEM_ADDR_W, r);
            pool[i + 8] = {r[ADDR_W-MEM_ADDR_W-1:0], pool[i][MEM_ADDR_W-1:0]};
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            take_bits(4, r);
            a = pool[r[3:0]];
            take_bits(DATA_W, r);
            d = r[DATA_W-1:0];
            take_bits(2, r);
            case (r[1:0])
                2'd1:    read_cmd(CMD_READ_AT, a);
                2'd2:    read_cmd(CMD_READ_NEXT, a);
                default: write_at(a, d);
            endcase
        end

        $display("%0d checks, %0d errors, %0d stall timeouts", checks, errors, stall_fails);
        if (errors == 0 && stall_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired after %0d ns with frames still running", LIMIT_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
src/spi_bridge_pkg.sv
src/bus_if.sv
src/spi_sync.sv
src/spi_shifter.sv
src/spi_cmd_decoder.sv
src/bus_memory.sv
src/spi_bridge_top.sv
test/spi_host.sv
test/spi_bridge_tb.sv

//--- Makefile
TOOL    = verilator
FLAGS   = --binary --timing -j 0
TOP     = spi_bridge_tb
FILELIST = project.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
